/* hw/tqv_periph_pkg.sv */
/*
 * Shared constants, bus access codes and the address view for the peripheral subsystem.
 * ADDR_BITS must stay equal to SLOT_BITS + OFFSET_BITS or the address union will not line up.
 */
package tqv_periph_pkg;

    // Subsystem geometry
    localparam int NUM_PERIPH  = 4;                       // Slots behind the decoder
    localparam int SLOT_BITS   = 2;                       // Enough to index NUM_PERIPH slots
    localparam int OFFSET_BITS = 6;                       // Register space inside one slot
    localparam int ADDR_BITS   = SLOT_BITS + OFFSET_BITS; // Full byte address seen on the bus

    // Access size codes, shared by data_write_n and data_read_n
    localparam logic [1:0] ACC_BYTE = 2'b00;
    localparam logic [1:0] ACC_HALF = 2'b01;
    localparam logic [1:0] ACC_WORD = 2'b10;
    localparam logic [1:0] ACC_NONE = 2'b11; // Idle strobe, no access this cycle

    // Register offsets inside a slot
    localparam logic [OFFSET_BITS-1:0] OFF_DATA    = 6'h00; // Read/write data register
    localparam logic [OFFSET_BITS-1:0] OFF_INPUT   = 6'h04; // Input PMOD readback
    localparam logic [OFFSET_BITS-1:0] OFF_INT_CLR = 6'h08; // Write 1 to bit 0 to clear irq

    // The bus address is used both as a flat byte address and as slot plus offset
    typedef union packed {
        logic [ADDR_BITS-1:0] raw; // Byte address as driven by the core
        struct packed {
            logic [SLOT_BITS-1:0]   slot;   // Upper bits pick the slot
            logic [OFFSET_BITS-1:0] offset; // Lower bits pick the register
        } fields;
    } periph_addr_u;

endpackage

/* hw/periph_bus_if.sv */
/*
 * Decoded access from the address decoder to the slots.
 * Plain strobes only, there is no handshake and no back-pressure.
 */
interface periph_bus_if import tqv_periph_pkg::*; ();

    logic [OFFSET_BITS-1:0] offset;  // Register offset inside the selected slot
    logic [31:0]            wdata;   // Write data, valid lanes depend on write_n
    logic [1:0]             write_n; // ACC_NONE when idle
    logic [1:0]             read_n;  // ACC_NONE when idle
    logic [NUM_PERIPH-1:0]  sel;     // One bit per slot, high only during an access

    // The decoder produces every field of the access
    modport decoder (
        output offset,
        output wdata,
        output write_n,
        output read_n,
        output sel
    );

    // Each slot only looks, and only at its own bit of sel
    modport slot (
        input offset,
        input wdata,
        input write_n,
        input read_n,
        input sel
    );

endinterface

/* hw/periph_select.sv */
/*
 * Combinational address decoder, no registers and no clock.
 * sel is all zero whenever both strobes are idle, so slots never see a stale enable.
 */
module periph_select import tqv_periph_pkg::*; (
    input  periph_addr_u          address,      // Core address, read through the fields view
    input  logic [31:0]           data_in,      // Write data from the core
    input  logic [1:0]            data_write_n, // Write size or ACC_NONE
    input  logic [1:0]            data_read_n,  // Read size or ACC_NONE
    periph_bus_if.decoder         bus           // Decoded access toward the slots
);

    logic                  access;  // Any read or write this cycle
    logic [NUM_PERIPH-1:0] sel_vec; // One-hot slot enable

    // An access exists whenever either strobe leaves the idle code
    assign access = (data_write_n != ACC_NONE) || (data_read_n != ACC_NONE);

    // Slot field becomes a one-hot vector, gated by the access
    always_comb begin
        sel_vec = '0;
        if (access) begin
            sel_vec[address.fields.slot] = 1'b1; // Exactly one slot per access
        end
    end

    // Offset and write data go to every slot, only the enabled slot acts on them
    assign bus.offset  = address.fields.offset;
    assign bus.wdata   = data_in;
    assign bus.write_n = data_write_n;
    assign bus.read_n  = data_read_n;
    assign bus.sel     = sel_vec;

endmodule

/* hw/periph_reg_slot.sv */
/*
 * One peripheral slot with a data register, input PMOD read and a rising edge interrupt.
 * The interrupt watches ui_in bit SLOT_INDEX through two flops, so it is set two edges late.
 */
module periph_reg_slot import tqv_periph_pkg::*; #(
    parameter int SLOT_INDEX = 0 // Which ui_in bit raises this slot's interrupt
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  ui_in,    // Input PMOD, shared by all slots
    periph_bus_if.slot  bus,      // Decoded access from the decoder
    output logic [31:0] rdata,    // Read value for the current offset
    output logic [7:0]  out_byte, // Register low byte, candidate for uo_out
    output logic        irq       // Level interrupt until cleared
);

    logic [31:0] data_reg; // The read/write register at OFF_DATA
    logic        wr_en;    // This slot is enabled for a write
    logic        ui_sync;  // First stage on the watched input bit
    logic        ui_prev;  // Previous value of ui_sync for edge detect
    logic        ui_rise;  // Rising edge seen on the watched bit
    logic        irq_clr;  // Clear request from the bus

    assign wr_en = bus.sel[SLOT_INDEX] && (bus.write_n != ACC_NONE);

    // Byte lanes follow the access size
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_reg <= '0;
        end else if (wr_en && (bus.offset == OFF_DATA)) begin
            data_reg[7:0] <= bus.wdata[7:0]; // Low byte is written by every size
            if ((bus.write_n == ACC_HALF) || (bus.write_n == ACC_WORD)) begin
                data_reg[15:8] <= bus.wdata[15:8];
            end
            if (bus.write_n == ACC_WORD) begin
                data_reg[31:16] <= bus.wdata[31:16]; // Upper half only for word writes
            end
        end
    end

    // Read mux by offset, unknown offsets read zero
    always_comb begin
        case (bus.offset)
            OFF_DATA:  rdata = data_reg;
            OFF_INPUT: rdata = {24'h0, ui_in}; // Zero-extended input PMOD
            default:   rdata = '0;
        endcase
    end

    assign out_byte = data_reg[7:0];

    // Register the watched bit first, then compare with its own delayed copy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ui_sync <= 1'b0;
            ui_prev <= 1'b0;
        end else begin
            ui_sync <= ui_in[SLOT_INDEX];
            ui_prev <= ui_sync;
        end
    end

    assign ui_rise = ui_sync && !ui_prev;
    assign irq_clr = wr_en && (bus.offset == OFF_INT_CLR) && bus.wdata[0];

    // A new edge beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq <= 1'b0;
        end else if (ui_rise) begin
            irq <= 1'b1;
        end else if (irq_clr) begin
            irq <= 1'b0;
        end
    end

    // An enabled slot always sees exactly one live strobe from the decoder
    sel_one_strobe_a: assert property (@(posedge clk) disable iff (!rst_n)
        bus.sel[SLOT_INDEX] |-> ((bus.write_n != ACC_NONE) != (bus.read_n != ACC_NONE)))
        else $error("slot %0d: enabled with write_n %b read_n %b",
                    SLOT_INDEX, bus.write_n, bus.read_n);

endmodule

/* hw/periph_readback.sv */
/*
 * Registered read path, output PMOD routing and interrupt packing.
 * data_out holds between reads, and every read gives exactly one data_ready pulse.
 */
module periph_readback import tqv_periph_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  periph_addr_u          address,                  // Core address, same cycle as strobes
    input  logic [1:0]            data_read_n,              // Read size or ACC_NONE
    input  logic [1:0]            data_write_n,             // Write size or ACC_NONE
    input  logic [31:0]           rdata    [NUM_PERIPH],    // Read value of each slot
    input  logic [7:0]            out_byte [NUM_PERIPH],    // Low byte of each slot register
    input  logic                  irq      [NUM_PERIPH],    // Interrupt of each slot
    output logic [31:0]           data_out,                 // Read data, valid with data_ready
    output logic                  data_ready,               // One-cycle pulse after a read
    output logic [7:0]            uo_out,                   // Output PMOD
    output logic [NUM_PERIPH-1:0] user_interrupt            // Interrupt vector to the core
);

    logic                 rd_req;    // A read is on the bus this cycle
    logic                 data_wr;   // A write to OFF_DATA of some slot
    logic [SLOT_BITS-1:0] out_slot;  // Slot whose byte drives uo_out

    assign rd_req  = (data_read_n != ACC_NONE);
    assign data_wr = (data_write_n != ACC_NONE) && (address.fields.offset == OFF_DATA);

    // Capture the addressed slot's value at the edge that ends the read cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_out   <= '0;
            data_ready <= 1'b0;
        end else begin
            data_ready <= rd_req; // Back-to-back reads give back-to-back pulses
            if (rd_req) begin
                data_out <= rdata[address.fields.slot];
            end
        end
    end

    // Remember the last written slot, slot 0 out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_slot <= '0;
        end else if (data_wr) begin
            out_slot <= address.fields.slot;
        end
    end

    // The slot register and out_slot change on the same edge, so uo_out follows at once
    assign uo_out = out_byte[out_slot];

    // Per-slot interrupts into one vector, bit N from slot N
    always_comb begin
        for (int i = 0; i < NUM_PERIPH; i++) begin
            user_interrupt[i] = irq[i];
        end
    end

endmodule

/* hw/tqv_periph_subsys.sv */
/*
 * Four peripheral slots behind one decoder, with a shared readback block.
 * Accesses take one cycle to read back and writes land on the first edge.
 */
module tqv_periph_subsys import tqv_periph_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [7:0]            ui_in,          // Input PMOD
    output logic [7:0]            uo_out,         // Output PMOD
    input  logic [ADDR_BITS-1:0]  address,        // Byte address from the core
    input  logic [31:0]           data_in,        // Write data
    input  logic [1:0]            data_write_n,   // Write size or ACC_NONE
    input  logic [1:0]            data_read_n,    // Read size or ACC_NONE
    output logic [31:0]           data_out,       // Read data
    output logic                  data_ready,     // Read completion pulse
    output logic [NUM_PERIPH-1:0] user_interrupt  // One interrupt per slot
);

    periph_addr_u addr_u;                     // Same address, split into slot and offset
    logic [31:0]  slot_rdata    [NUM_PERIPH]; // Read value from each slot
    logic [7:0]   slot_out_byte [NUM_PERIPH]; // Register low byte from each slot
    logic         slot_irq      [NUM_PERIPH]; // Interrupt from each slot

    periph_bus_if bus ();

    assign addr_u.raw = address;

    periph_select u_select (
        .address      (addr_u),
        .data_in      (data_in),
        .data_write_n (data_write_n),
        .data_read_n  (data_read_n),
        .bus          (bus.decoder)
    );

    // Slot i watches ui_in bit i for its interrupt
    for (genvar i = 0; i < NUM_PERIPH; i++) begin : g_slot
        periph_reg_slot #(
            .SLOT_INDEX (i)
        ) u_slot (
            .clk      (clk),
            .rst_n    (rst_n),
            .ui_in    (ui_in),
            .bus      (bus.slot),
            .rdata    (slot_rdata[i]),
            .out_byte (slot_out_byte[i]),
            .irq      (slot_irq[i])
        );
    end

    periph_readback u_readback (
        .clk            (clk),
        .rst_n          (rst_n),
        .address        (addr_u),
        .data_read_n    (data_read_n),
        .data_write_n   (data_write_n),
        .rdata          (slot_rdata),
        .out_byte       (slot_out_byte),
        .irq            (slot_irq),
        .data_out       (data_out),
        .data_ready     (data_ready),
        .uo_out         (uo_out),
        .user_interrupt (user_interrupt)
    );

endmodule

/* verification/tb_tqv_periph_tests.svh */
/*
 * Directed tests for the subsystem, included into the testbench module body.
 * They run in order, and later tests rely on the slot contents left by earlier ones.
 */
`ifndef TB_TQV_PERIPH_TESTS_SVH
`define TB_TQV_PERIPH_TESTS_SVH

    // Everything is quiet and zero straight out of reset
    task automatic reset_state();
        logic [31:0] rdata;
        int          latency;
        check_value("reset_state", 32'h0, 32'(user_interrupt));
        check_value("reset_state", 32'h0, 32'(uo_out)); // Slot 0 routed, register zero
        check_value("reset_state", 32'h0, data_out); // Read data register cleared
        for (int i = 0; i < 4; i++) begin
            idle_cycles(1);
            check_value("reset_state", 32'h0, 32'(data_ready)); // No access, no pulse
        end
        for (int slot = 0; slot < NUM_PERIPH; slot++) begin
            read_reg(addr_of(slot, OFF_DATA), rdata, latency);
            check_value("reset_state", 32'h0, rdata);
        end
    endtask

    task automatic slot_independence();
        logic [31:0] rdata;
        int          latency;
        for (int slot = 0; slot < NUM_PERIPH; slot++) begin
            model_write(slot, $random(seed), ACC_WORD);
        end
        // Back to back reads, each must return its own slot's word one cycle later
        for (int slot = 0; slot < NUM_PERIPH; slot++) begin
            read_reg(addr_of(slot, OFF_DATA), rdata, latency);
            check_value("slot_independence", model[slot], rdata);
            check_value("slot_independence latency", 32'd1, 32'(latency));
        end
        idle_cycles(1);
        check_value("slot_independence pulse", 32'h0, 32'(data_ready)); // Pulse is one cycle
    endtask

    // Byte and half writes over a known word only touch their own lanes
    task automatic partial_writes();
        logic [31:0] rdata;
        int          latency;
        logic [1:0]  sizes [3];
        sizes[0] = ACC_BYTE;
        sizes[1] = ACC_HALF;
        sizes[2] = ACC_WORD;
        model_write(1, 32'h1122_3344, ACC_WORD);
        model_write(1, 32'hAABB_CCDD, ACC_BYTE);
        read_reg(addr_of(1, OFF_DATA), rdata, latency);
        check_value("partial_writes byte", model[1], rdata); // Expect 0x112233DD
        model_write(1, 32'h5566_7788, ACC_HALF);
        read_reg(addr_of(1, OFF_DATA), rdata, latency);
        check_value("partial_writes half", model[1], rdata);
        for (int k = 0; k < 3; k++) begin
            model_write(2, $random(seed), sizes[k]);
            read_reg(addr_of(2, OFF_DATA), rdata, latency);
            check_value("partial_writes random", model[2], rdata);
        end
        read_reg(addr_of(0, OFF_DATA), rdata, latency);
        check_value("partial_writes other slot", model[0], rdata); // Slot 0 untouched
    endtask

    task automatic input_and_unmapped_reads();
        logic [31:0] rdata;
        int          latency;
        logic [7:0]  ui_val;
        for (int slot = 0; slot < NUM_PERIPH; slot++) begin
            ui_val = 8'($random(seed));
            ui_in  = ui_val;
            read_reg(addr_of(slot, OFF_INPUT), rdata, latency);
            check_value("input_and_unmapped_reads input", {24'h0, ui_val}, rdata);
            read_reg(addr_of(slot, 6'h0C), rdata, latency); // Offset 12 has no register
            check_value("input_and_unmapped_reads offset 12", 32'h0, rdata);
        end
        // Random inputs may have raised interrupts, so settle and clear them all
        ui_in = '0;
        idle_cycles(3);
        for (int slot = 0; slot < NUM_PERIPH; slot++) begin
            clear_irq(slot);
        end
        check_value("input_and_unmapped_reads irq clear", 32'h0, 32'(user_interrupt));
    endtask

    task automatic edge_interrupt();
        int cycles;
        ui_in  = 8'h04;
        cycles = 0;
        while (user_interrupt == '0 && cycles < IRQ_TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (user_interrupt == '0) begin
            abort_run($sformatf("user_interrupt did not rise within %0d cycles", IRQ_TIMEOUT));
        end
        check_value("edge_interrupt set", 32'h4, 32'(user_interrupt)); // Only slot 2
        check_value("edge_interrupt delay", 32'd2, 32'(cycles)); // Input is registered first
        write_reg(addr_of(2, OFF_INT_CLR), 32'hFFFF_FFFE, ACC_WORD);
        check_value("edge_interrupt bit 0 low", 32'h4, 32'(user_interrupt));
        clear_irq(1); // Clear aimed at another slot
        check_value("edge_interrupt other slot", 32'h4, 32'(user_interrupt));
        clear_irq(2);
        check_value("edge_interrupt clear", 32'h0, 32'(user_interrupt));
        ui_in = '0;
        idle_cycles(3);
        check_value("edge_interrupt falling", 32'h0, 32'(user_interrupt)); // Falling edge is quiet
    endtask

    task automatic output_pmod_routing();
        model_write(3, $random(seed), ACC_WORD);
        check_value("output_pmod_routing slot 3", 32'(model[3][7:0]), 32'(uo_out));
        model_write(1, $random(seed), ACC_BYTE);
        check_value("output_pmod_routing slot 1", 32'(model[1][7:0]), 32'(uo_out));
        // A write to another offset must not move the routing
        write_reg(addr_of(0, OFF_INT_CLR), 32'h0, ACC_WORD);
        check_value("output_pmod_routing hold", 32'(model[1][7:0]), 32'(uo_out));
    endtask

`endif

/* verification/tb_tqv_periph.sv */
/*
 * Directed testbench for the peripheral subsystem. Inputs change 2 units after the rising
 * edge and outputs are sampled at that same point. The first failed check ends the run.
 */
module tb_tqv_periph import tqv_periph_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int READ_TIMEOUT = 16; // Cycles a read may wait for data_ready
    localparam int IRQ_TIMEOUT  = 16; // Cycles an interrupt may take to rise

    logic                  clk;
    logic                  rst_n;
    logic [7:0]            ui_in;
    logic [7:0]            uo_out;
    logic [ADDR_BITS-1:0]  address;
    logic [31:0]           data_in;
    logic [1:0]            data_write_n;
    logic [1:0]            data_read_n;
    logic [31:0]           data_out;
    logic                  data_ready;
    logic [NUM_PERIPH-1:0] user_interrupt;

    integer      seed;              // Seed variable for $random
    int          error_count;
    logic [31:0] model [NUM_PERIPH]; // Expected content of each slot data register

    tqv_periph_subsys u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .ui_in          (ui_in),
        .uo_out         (uo_out),
        .address        (address),
        .data_in        (data_in),
        .data_write_n   (data_write_n),
        .data_read_n    (data_read_n),
        .data_out       (data_out),
        .data_ready     (data_ready),
        .user_interrupt (user_interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            abort_run($sformatf("[ERROR] %s: expected 0x%08h, actual 0x%08h",
                                test_name, expected, actual));
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Slot index in the upper address bits, register offset below
    function automatic logic [ADDR_BITS-1:0] addr_of(input int slot,
                                                     input logic [OFFSET_BITS-1:0] offset);
        return {slot[SLOT_BITS-1:0], offset};
    endfunction

    // Expected register after a write of the given size
    function automatic logic [31:0] merge_write(input logic [31:0] old_val,
                                                input logic [31:0] wdata,
                                                input logic [1:0]  size);
        case (size)
            ACC_BYTE: return {old_val[31:8], wdata[7:0]};
            ACC_HALF: return {old_val[31:16], wdata[15:0]};
            default:  return wdata; // Word write replaces all four lanes
        endcase
    endfunction

    // One-cycle write strobe, it lands on the next rising edge
    task automatic write_reg(input logic [ADDR_BITS-1:0] addr, input logic [31:0] wdata,
                             input logic [1:0] size);
        address      = addr;
        data_in      = wdata;
        data_write_n = size;
        @(posedge clk);
        #2;
        data_write_n = ACC_NONE;
    endtask

    // Read strobe for one cycle, then wait for data_ready with a bound
    task automatic read_reg(input logic [ADDR_BITS-1:0] addr, output logic [31:0] rdata,
                            output int latency);
        int cycles;
        address     = addr;
        data_read_n = ACC_WORD;
        cycles      = 0;
        do begin
            @(posedge clk);
            #2;
            data_read_n = ACC_NONE;
            cycles++;
        end while (!data_ready && cycles < READ_TIMEOUT);
        if (!data_ready) begin
            abort_run($sformatf("Read at address 0x%02h got no data_ready within %0d cycles",
                                addr, READ_TIMEOUT));
        end
        rdata   = data_out;
        latency = cycles;
    endtask

    // Write the data register and keep the model in step
    task automatic model_write(input int slot, input logic [31:0] wdata, input logic [1:0] size);
        write_reg(addr_of(slot, OFF_DATA), wdata, size);
        model[slot] = merge_write(model[slot], wdata, size);
    endtask

    task automatic clear_irq(input int slot);
        write_reg(addr_of(slot, OFF_INT_CLR), 32'h1, ACC_WORD);
    endtask

`include "tb_tqv_periph_tests.svh"

    initial begin
        seed         = 32'h1e7a;
        error_count  = 0;
        rst_n        = 1'b0;
        ui_in        = '0;
        address      = '0;
        data_in      = '0;
        data_write_n = ACC_NONE;
        data_read_n  = ACC_NONE;
        for (int i = 0; i < NUM_PERIPH; i++) begin
            model[i] = '0; // Registers come out of reset as zero
        end
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        reset_state();
        slot_independence();
        partial_writes();
        input_and_unmapped_reads();
        edge_interrupt();
        output_pmod_routing();

        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "%0d checks failed", error_count);
        end
    end

endmodule

/* tb.f */
+incdir+verification
hw/tqv_periph_pkg.sv
hw/periph_bus_if.sv
hw/periph_select.sv
hw/periph_reg_slot.sv
hw/periph_readback.sv
hw/tqv_periph_subsys.sv
verification/tb_tqv_periph.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it, the result comes from the printed output
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_tqv_periph -f tb.f -o sim_tb

status=0
output=$(./obj_dir/sim_tb 2>&1) || status=$?
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
echo "Simulation did not report a pass (exit status $status)"
exit 1
